/* hw/integrity_pkg.sv */
// Bus request widths and checksum helpers shared by the instruction and data request checkers
`default_nettype none

package integrity_pkg;

  //////////////////////////////
  // Request channel widths
  //////////////////////////////

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned WDATA_W   = 32;
  localparam int unsigned PROT_W    = 3;
  localparam int unsigned MEMTYPE_W = 2;
  localparam int unsigned BE_W      = 4;

  // Address-phase checksum carried next to every request
  localparam int unsigned ACHK_W = 12;

  typedef logic [ACHK_W-1:0] achk_t;

  //////////////////////////////
  // Checksum helpers
  //////////////////////////////

  // Even parity of each byte lane, bit 0 belongs to the lowest byte
  function automatic logic [BE_W-1:0] byte_parity4(input logic [WDATA_W-1:0] word);
    logic [BE_W-1:0] par;
    par = '0;
    for (int i = 0; i < BE_W; i++) begin
      par[i] = ^word[8*i +: 8];
    end
    return par;
  endfunction

endpackage

`default_nettype wire

/* hw/trap_pkg.sv */
// PC, privilege and exception code definitions shared by the trap PC trackers and checker
`default_nettype none

package trap_pkg;

  //////////////////////////////
  // Program counter
  //////////////////////////////

  localparam int unsigned PC_W = 32;

  typedef logic [PC_W-1:0] pc_t;

  // Privilege levels as encoded by the core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_e;

  // PC source select, only the NMI entry is decoded by the monitor
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,
    PC_JUMP      = 4'b0010,
    PC_BRANCH    = 4'b0011,
    PC_MRET      = 4'b0101,
    PC_DRET      = 4'b0111,
    PC_WB_PLUS4  = 4'b1000,
    PC_TRAP_EXC  = 4'b1001,
    PC_TRAP_IRQ  = 4'b1010,
    PC_TRAP_DBD  = 4'b1011,
    PC_TRAP_DBE  = 4'b1100,
    PC_TRAP_NMI  = 4'b1110
  } pc_mux_e;

  //////////////////////////////
  // Exception causes
  //////////////////////////////

  localparam int unsigned EXC_CODE_W = 11;

  typedef logic [EXC_CODE_W-1:0] exc_code_t;

  localparam exc_code_t EXC_CAUSE_INSTR_FAULT     = 11'h01;
  localparam exc_code_t EXC_CAUSE_ILLEGAL_INSN    = 11'h02;
  localparam exc_code_t EXC_CAUSE_BREAKPOINT      = 11'h03;
  localparam exc_code_t EXC_CAUSE_ECALL_UMODE     = 11'h08;
  localparam exc_code_t EXC_CAUSE_ECALL_MMODE     = 11'h0B;
  localparam exc_code_t EXC_CAUSE_INSTR_BUS_FAULT = 11'h18;

  // One bit or one PC entry per tracked trap cause
  localparam int unsigned NUM_TRAP_CAUSES = 6;

  localparam int unsigned CAUSE_IDX_ILLEGAL = 0;
  localparam int unsigned CAUSE_IDX_ECALL_M = 1;
  localparam int unsigned CAUSE_IDX_ECALL_U = 2;
  localparam int unsigned CAUSE_IDX_EBRK    = 3;
  localparam int unsigned CAUSE_IDX_BUS_ERR = 4;
  localparam int unsigned CAUSE_IDX_MPU     = 5;

  typedef logic [NUM_TRAP_CAUSES-1:0] cause_vec_t;
  typedef logic [NUM_TRAP_CAUSES-1:0][PC_W-1:0] pc_array_t;

endpackage

`default_nettype wire

/* hw/instr_req_checker.sv */
// Instruction fetch request checker, rebuilds parity and checksum and raises a sticky alarm
`default_nettype none

module instr_req_checker
  import integrity_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_ni,
  input  wire logic                 req_i,
  input  wire logic                 reqpar_i,
  input  wire logic [ADDR_W-1:0]    addr_i,
  input  wire achk_t                achk_i,
  input  wire logic [MEMTYPE_W-1:0] memtype_i,
  input  wire logic [PROT_W-1:0]    prot_i,
  input  wire logic                 dbg_i,
  output logic                      err_o
);

  logic  reqpar_exp;
  achk_t achk_exp;
  logic  err_q;

  // Request parity is the complement of req
  assign reqpar_exp = ~req_i;

  // Fetches always use all byte lanes and read direction, so bit 5 is a constant
  // Fetches carry no write data and the upper nibble stays zero
  assign achk_exp = {
    {BE_W{1'b0}},
    1'b0,
    ~dbg_i,
    ~^{{BE_W{1'b1}}, 1'b0},
    ~^{prot_i, memtype_i},
    byte_parity4(addr_i)
  };

  // Any difference in any cycle arms the alarm until reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if ((reqpar_i != reqpar_exp) || (achk_i != achk_exp)) begin
      err_q <= 1'b1;
    end
  end

  assign err_o = err_q;

endmodule

`default_nettype wire

/* hw/data_req_checker.sv */
// Data request checker, rebuilds parity and full checksum including write data and raises an alarm
`default_nettype none

module data_req_checker
  import integrity_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_ni,
  input  wire logic                 req_i,
  input  wire logic                 reqpar_i,
  input  wire logic [ADDR_W-1:0]    addr_i,
  input  wire achk_t                achk_i,
  input  wire logic [MEMTYPE_W-1:0] memtype_i,
  input  wire logic [PROT_W-1:0]    prot_i,
  input  wire logic                 dbg_i,
  input  wire logic                 we_i,
  input  wire logic [BE_W-1:0]      be_i,
  input  wire logic [WDATA_W-1:0]   wdata_i,
  output logic                      err_o
);

  logic            reqpar_exp;
  logic [BE_W-1:0] wdata_par;
  logic [BE_W-1:0] addr_par;
  achk_t           achk_exp;
  logic            par_err;
  logic            achk_err;
  logic            err_q;

  assign reqpar_exp = ~req_i;

  // Byte lane parities of the address and the write data
  assign addr_par  = byte_parity4(addr_i);
  assign wdata_par = byte_parity4(wdata_i);

  // Checksum layout, write data lanes on top, then a zero bit, dbg,
  // direction with byte enables, attributes, and address lanes at the bottom
  assign achk_exp = {
    wdata_par,
    1'b0,
    ~dbg_i,
    ~^{be_i, we_i},
    ~^{prot_i, memtype_i},
    addr_par
  };

  // Both checks run every cycle, idle cycles included
  assign par_err  = (reqpar_i != reqpar_exp);
  assign achk_err = (achk_i != achk_exp);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if (par_err || achk_err) begin
      err_q <= 1'b1;
    end
  end

  assign err_o = err_q;

endmodule

`default_nettype wire

/* hw/trap_expect_tracker.sv */
// Records the writeback PC of the first instruction that should trap for each cause
`default_nettype none

module trap_expect_tracker
  import trap_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_ni,
  input  wire logic     wb_valid_i,
  input  wire pc_t      wb_pc_i,
  input  wire logic     wb_illegal_i,
  input  wire logic     wb_sys_en_i,
  input  wire logic     wb_ecall_i,
  input  wire logic     wb_ebrk_i,
  input  wire logic     wb_bus_err_i,
  input  wire logic     wb_mpu_fault_i,
  input  wire logic     irq_ack_i,
  input  wire logic     dbg_async_pend_i,
  input  wire logic     dbg_async_allow_i,
  input  wire logic     dbg_sync_pend_i,
  input  wire logic     dbg_sync_allow_i,
  input  wire pc_mux_e  pc_mux_i,
  input  wire logic     debug_mode_n_i,
  input  wire privlvl_e priv_lvl_i,
  output cause_vec_t    found_o,
  output pc_array_t     expected_pc_o
);

  logic       pending_debug;
  logic       wb_qual;
  logic       fetch_fault;
  logic       is_ecall;
  logic       is_ebrk;
  cause_vec_t hit;
  cause_vec_t found_q;
  pc_array_t  pc_q;

  // Debug entry takes over the writeback instruction, no exception is taken then
  assign pending_debug = (dbg_async_pend_i && dbg_async_allow_i) ||
                         (dbg_sync_pend_i && dbg_sync_allow_i);

  // Common qualifier, a valid instruction that is not replaced by an
  // interrupt, a debug entry or an NMI
  assign wb_qual = wb_valid_i && !irq_ack_i && !pending_debug && (pc_mux_i != PC_TRAP_NMI);

  assign fetch_fault = wb_bus_err_i || wb_mpu_fault_i;
  assign is_ecall    = wb_sys_en_i && wb_ecall_i;
  assign is_ebrk     = wb_sys_en_i && wb_ebrk_i;

  //////////////////////////////
  // Exception priority
  //////////////////////////////

  // MPU fault wins over bus error, both win over illegal, illegal wins over ecall
  // and ecall wins over ebreak
  always_comb begin
    hit = '0;
    hit[CAUSE_IDX_MPU]     = wb_qual && wb_mpu_fault_i && !debug_mode_n_i;
    hit[CAUSE_IDX_BUS_ERR] = wb_qual && wb_bus_err_i && !wb_mpu_fault_i && !debug_mode_n_i;
    hit[CAUSE_IDX_ILLEGAL] = wb_qual && wb_illegal_i && !fetch_fault && !debug_mode_n_i;
    hit[CAUSE_IDX_ECALL_M] = wb_qual && is_ecall && !fetch_fault && !wb_illegal_i &&
                             !debug_mode_n_i && (priv_lvl_i == PRIV_LVL_M);
    hit[CAUSE_IDX_ECALL_U] = wb_qual && is_ecall && !fetch_fault && !wb_illegal_i &&
                             !debug_mode_n_i && (priv_lvl_i == PRIV_LVL_U);
    // An ebreak may itself be the debug entry, so debug_mode_n is not looked at
    hit[CAUSE_IDX_EBRK]    = wb_qual && is_ebrk && !fetch_fault && !wb_illegal_i && !is_ecall;
  end

  //////////////////////////////
  // First occurrence capture
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | hit;
    end
  end

  // The PC is only meaningful once the matching found bit is set
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_TRAP_CAUSES; i++) begin
      if (hit[i] && !found_q[i]) begin
        pc_q[i] <= wb_pc_i;
      end
    end
  end

  assign found_o       = found_q;
  assign expected_pc_o = pc_q;

endmodule

`default_nettype wire

/* hw/trap_save_tracker.sv */
// Records the first mepc value saved by the core for each tracked exception cause
`default_nettype none

module trap_save_tracker
  import trap_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_ni,
  input  wire logic      csr_save_cause_i,
  input  wire logic      cause_irq_i,
  input  wire exc_code_t cause_code_i,
  input  wire pc_t       mepc_n_i,
  output cause_vec_t     found_o,
  output pc_array_t      saved_mepc_o
);

  logic       exc_save;
  cause_vec_t code_dec;
  cause_vec_t hit;
  cause_vec_t found_q;
  pc_array_t  mepc_q;

  // Interrupt saves are not exceptions and are ignored here
  assign exc_save = csr_save_cause_i && !cause_irq_i;

  // One-hot decode of the saved exception code
  always_comb begin
    code_dec = '0;
    case (cause_code_i)
      EXC_CAUSE_ILLEGAL_INSN:    code_dec[CAUSE_IDX_ILLEGAL] = 1'b1;
      EXC_CAUSE_ECALL_MMODE:     code_dec[CAUSE_IDX_ECALL_M] = 1'b1;
      EXC_CAUSE_ECALL_UMODE:     code_dec[CAUSE_IDX_ECALL_U] = 1'b1;
      EXC_CAUSE_BREAKPOINT:      code_dec[CAUSE_IDX_EBRK]    = 1'b1;
      EXC_CAUSE_INSTR_BUS_FAULT: code_dec[CAUSE_IDX_BUS_ERR] = 1'b1;
      EXC_CAUSE_INSTR_FAULT:     code_dec[CAUSE_IDX_MPU]     = 1'b1;
      default:                   code_dec = '0;
    endcase
  end

  assign hit = exc_save ? code_dec : '0;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | hit;
    end
  end

  // Later saves of the same cause leave the first value untouched
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_TRAP_CAUSES; i++) begin
      if (hit[i] && !found_q[i]) begin
        mepc_q[i] <= mepc_n_i;
      end
    end
  end

  assign found_o      = found_q;
  assign saved_mepc_o = mepc_q;

endmodule

`default_nettype wire

/* hw/mepc_match_checker.sv */
// Compares expected and saved mepc per trap cause and keeps sticky checked and mismatch flags
`default_nettype none

module mepc_match_checker
  import trap_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_ni,
  input  wire cause_vec_t expect_found_i,
  input  wire cause_vec_t save_found_i,
  input  wire pc_array_t  expected_pc_i,
  input  wire pc_array_t  saved_mepc_i,
  output cause_vec_t      checked_o,
  output cause_vec_t      mismatch_o
);

  cause_vec_t both_found;
  cause_vec_t pc_differs;
  cause_vec_t checked_q;
  cause_vec_t mismatch_q;

  // A cause can only be judged once both trackers hold a value for it
  assign both_found = expect_found_i & save_found_i;

  always_comb begin
    for (int i = 0; i < NUM_TRAP_CAUSES; i++) begin
      pc_differs[i] = (expected_pc_i[i] != saved_mepc_i[i]);
    end
  end

  // Flags follow the found bits by one edge and then hold
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q  <= '0;
      mismatch_q <= '0;
    end else begin
      checked_q  <= checked_q | both_found;
      mismatch_q <= mismatch_q | (both_found & pc_differs);
    end
  end

  assign checked_o  = checked_q;
  assign mismatch_o = mismatch_q;

endmodule

`default_nettype wire

/* hw/core_integrity_monitor.sv */
// Top of the core monitor, connects the bus request checkers and the trap PC checkers
`default_nettype none

module core_integrity_monitor
  import integrity_pkg::*;
  import trap_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_ni,

  // Instruction request channel
  input  wire logic                 instr_req_i,
  input  wire logic                 instr_reqpar_i,
  input  wire logic [ADDR_W-1:0]    instr_addr_i,
  input  wire achk_t                instr_achk_i,
  input  wire logic [MEMTYPE_W-1:0] instr_memtype_i,
  input  wire logic [PROT_W-1:0]    instr_prot_i,
  input  wire logic                 instr_dbg_i,

  // Data request channel
  input  wire logic                 data_req_i,
  input  wire logic                 data_reqpar_i,
  input  wire logic [ADDR_W-1:0]    data_addr_i,
  input  wire achk_t                data_achk_i,
  input  wire logic [MEMTYPE_W-1:0] data_memtype_i,
  input  wire logic [PROT_W-1:0]    data_prot_i,
  input  wire logic                 data_dbg_i,
  input  wire logic                 data_we_i,
  input  wire logic [BE_W-1:0]      data_be_i,
  input  wire logic [WDATA_W-1:0]   data_wdata_i,

  // Writeback stage and controller status
  input  wire logic                 wb_valid_i,
  input  wire pc_t                  wb_pc_i,
  input  wire logic                 wb_illegal_i,
  input  wire logic                 wb_sys_en_i,
  input  wire logic                 wb_ecall_i,
  input  wire logic                 wb_ebrk_i,
  input  wire logic                 wb_bus_err_i,
  input  wire logic                 wb_mpu_fault_i,
  input  wire logic                 irq_ack_i,
  input  wire logic                 dbg_async_pend_i,
  input  wire logic                 dbg_async_allow_i,
  input  wire logic                 dbg_sync_pend_i,
  input  wire logic                 dbg_sync_allow_i,
  input  wire pc_mux_e              pc_mux_i,
  input  wire logic                 debug_mode_n_i,
  input  wire privlvl_e             priv_lvl_i,

  // CSR cause save
  input  wire logic                 csr_save_cause_i,
  input  wire logic                 cause_irq_i,
  input  wire exc_code_t            cause_code_i,
  input  wire pc_t                  mepc_n_i,

  output logic                      instr_integrity_err_o,
  output logic                      data_integrity_err_o,
  output cause_vec_t                mepc_checked_o,
  output cause_vec_t                mepc_mismatch_o
);

  cause_vec_t expect_found;
  cause_vec_t save_found;
  pc_array_t  expected_pc;
  pc_array_t  saved_mepc;

  //////////////////////////////
  // Bus request integrity
  //////////////////////////////

  instr_req_checker u_instr_req_checker (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .req_i     (instr_req_i),
    .reqpar_i  (instr_reqpar_i),
    .addr_i    (instr_addr_i),
    .achk_i    (instr_achk_i),
    .memtype_i (instr_memtype_i),
    .prot_i    (instr_prot_i),
    .dbg_i     (instr_dbg_i),
    .err_o     (instr_integrity_err_o)
  );

  data_req_checker u_data_req_checker (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .req_i     (data_req_i),
    .reqpar_i  (data_reqpar_i),
    .addr_i    (data_addr_i),
    .achk_i    (data_achk_i),
    .memtype_i (data_memtype_i),
    .prot_i    (data_prot_i),
    .dbg_i     (data_dbg_i),
    .we_i      (data_we_i),
    .be_i      (data_be_i),
    .wdata_i   (data_wdata_i),
    .err_o     (data_integrity_err_o)
  );

  //////////////////////////////
  // Trap PC checking
  //////////////////////////////

  trap_expect_tracker u_trap_expect_tracker (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .wb_valid_i        (wb_valid_i),
    .wb_pc_i           (wb_pc_i),
    .wb_illegal_i      (wb_illegal_i),
    .wb_sys_en_i       (wb_sys_en_i),
    .wb_ecall_i        (wb_ecall_i),
    .wb_ebrk_i         (wb_ebrk_i),
    .wb_bus_err_i      (wb_bus_err_i),
    .wb_mpu_fault_i    (wb_mpu_fault_i),
    .irq_ack_i         (irq_ack_i),
    .dbg_async_pend_i  (dbg_async_pend_i),
    .dbg_async_allow_i (dbg_async_allow_i),
    .dbg_sync_pend_i   (dbg_sync_pend_i),
    .dbg_sync_allow_i  (dbg_sync_allow_i),
    .pc_mux_i          (pc_mux_i),
    .debug_mode_n_i    (debug_mode_n_i),
    .priv_lvl_i        (priv_lvl_i),
    .found_o           (expect_found),
    .expected_pc_o     (expected_pc)
  );

  trap_save_tracker u_trap_save_tracker (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .csr_save_cause_i (csr_save_cause_i),
    .cause_irq_i      (cause_irq_i),
    .cause_code_i     (cause_code_i),
    .mepc_n_i         (mepc_n_i),
    .found_o          (save_found),
    .saved_mepc_o     (saved_mepc)
  );

  mepc_match_checker u_mepc_match_checker (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .expect_found_i (expect_found),
    .save_found_i   (save_found),
    .expected_pc_i  (expected_pc),
    .saved_mepc_i   (saved_mepc),
    .checked_o      (mepc_checked_o),
    .mismatch_o     (mepc_mismatch_o)
  );

endmodule

`default_nettype wire

/* verif/tb_core_integrity_monitor.sv */
// Testbench for the core monitor, replays the vector file and checks the four alarm outputs per step
`default_nettype none

module tb_core_integrity_monitor
  import integrity_pkg::*;
  import trap_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic                 clk;
  logic                 rst_ni;
  logic                 instr_req_i, instr_reqpar_i, instr_dbg_i;
  logic [ADDR_W-1:0]    instr_addr_i;
  achk_t                instr_achk_i;
  logic [MEMTYPE_W-1:0] instr_memtype_i;
  logic [PROT_W-1:0]    instr_prot_i;
  logic                 data_req_i, data_reqpar_i, data_dbg_i, data_we_i;
  logic [ADDR_W-1:0]    data_addr_i;
  achk_t                data_achk_i;
  logic [MEMTYPE_W-1:0] data_memtype_i;
  logic [PROT_W-1:0]    data_prot_i;
  logic [BE_W-1:0]      data_be_i;
  logic [WDATA_W-1:0]   data_wdata_i;
  logic                 wb_valid_i, wb_illegal_i, wb_sys_en_i, wb_ecall_i, wb_ebrk_i;
  logic                 wb_bus_err_i, wb_mpu_fault_i, irq_ack_i;
  logic                 dbg_async_pend_i, dbg_async_allow_i, dbg_sync_pend_i, dbg_sync_allow_i;
  pc_t                  wb_pc_i;
  pc_mux_e              pc_mux_i;
  logic                 debug_mode_n_i;
  privlvl_e             priv_lvl_i;
  logic                 csr_save_cause_i, cause_irq_i;
  exc_code_t            cause_code_i;
  pc_t                  mepc_n_i;
  logic                 instr_integrity_err_o, data_integrity_err_o;
  cause_vec_t           mepc_checked_o, mepc_mismatch_o;

  // Hex fields of the current vector line and the outputs it expects after the next edge
  logic [31:0] fld [0:16];
  logic        exp_ierr, exp_derr;
  cause_vec_t  exp_checked, exp_mismatch;
  string       test_name, line_kind, line;
  int          fd, rc, vectors;

  core_integrity_monitor dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Error handling and checks
  //////////////////////////////

  task automatic abort_run(input string why);
    if (why.len() > 0) begin
      $display("%s", why);
    end
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_err(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      abort_run("");
    end
  endtask

  task automatic check_causes(input string what, input cause_vec_t exp, input cause_vec_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      abort_run("");
    end
  endtask

  // Polls at half-step offsets so it never lands on a clock edge, returns 1 ns after the rise
  task automatic wait_rise(input int limit);
    int  n;
    logic seen_low;
    n = 0;
    seen_low = 1'b0;
    #0.5;
    while (!(seen_low && clk === 1'b1)) begin
      if (clk === 1'b0) begin
        seen_low = 1'b1;
      end
      if (n >= limit) begin
        abort_run("timeout while waiting for a rising clock edge");
      end else begin
        n++;
        #1;
      end
    end
    #0.5;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Expected address-phase checksum built bit by bit from the bus rules
  function automatic achk_t calc_achk(input logic [31:0] addr, input logic [1:0] memtype,
                                      input logic [2:0] prot, input logic dbg, input logic we,
                                      input logic [3:0] be, input logic [31:0] wdata);
    achk_t sum;
    sum = '0;
    for (int b = 0; b < 4; b++) begin
      sum[b]     = ^addr[8*b +: 8];
      sum[8 + b] = ^wdata[8*b +: 8];
    end
    sum[4] = ~^{prot, memtype};
    sum[5] = ~^{be, we};
    sum[6] = ~dbg;
    return sum;
  endfunction

  task automatic set_bus_idle();
    {instr_req_i, instr_reqpar_i, instr_dbg_i} = 3'b010;
    {instr_addr_i, instr_memtype_i, instr_prot_i} = '0;
    // Fetches always look like a full-word read
    instr_achk_i = calc_achk(32'h0, 2'b00, 3'b000, 1'b0, 1'b0, 4'hf, 32'h0);
    {data_req_i, data_reqpar_i, data_dbg_i, data_we_i} = 4'b0100;
    {data_addr_i, data_memtype_i, data_prot_i, data_be_i, data_wdata_i} = '0;
    data_achk_i = calc_achk(32'h0, 2'b00, 3'b000, 1'b0, 1'b0, 4'h0, 32'h0);
  endtask

  task automatic set_trap_idle();
    {wb_valid_i, wb_illegal_i, wb_sys_en_i, wb_ecall_i, wb_ebrk_i} = '0;
    {wb_bus_err_i, wb_mpu_fault_i, irq_ack_i, debug_mode_n_i} = '0;
    {dbg_async_pend_i, dbg_async_allow_i, dbg_sync_pend_i, dbg_sync_allow_i} = '0;
    wb_pc_i = '0;
    pc_mux_i = PC_BOOT;
    priv_lvl_i = PRIV_LVL_M;
    {csr_save_cause_i, cause_irq_i} = 2'b00;
    cause_code_i = '0;
    mepc_n_i = '0;
  endtask

  task automatic apply_bus_line();
    {instr_req_i, instr_reqpar_i} = {fld[1][0], fld[2][0]};
    instr_addr_i = fld[3];
    instr_achk_i = fld[4][ACHK_W-1:0];
    {instr_dbg_i, instr_prot_i, instr_memtype_i} = fld[5][5:0];
    {data_req_i, data_reqpar_i} = {fld[6][0], fld[7][0]};
    data_addr_i = fld[8];
    data_achk_i = fld[9][ACHK_W-1:0];
    {data_dbg_i, data_prot_i, data_memtype_i} = fld[10][5:0];
    {data_we_i, data_be_i} = fld[11][4:0];
    data_wdata_i = fld[12];
    // Marked idle lines get random addresses with a freshly built checksum
    if (fld[0][0]) begin
      instr_addr_i = $urandom();
      data_addr_i  = $urandom();
      instr_achk_i = calc_achk(instr_addr_i, instr_memtype_i, instr_prot_i, instr_dbg_i,
                               1'b0, 4'hf, 32'h0);
      data_achk_i  = calc_achk(data_addr_i, data_memtype_i, data_prot_i, data_dbg_i,
                               data_we_i, data_be_i, data_wdata_i);
    end
    set_trap_idle();
    {exp_ierr, exp_derr} = {fld[13][0], fld[14][0]};
    {exp_checked, exp_mismatch} = {fld[15][5:0], fld[16][5:0]};
  endtask

  task automatic apply_trap_line();
    set_bus_idle();
    wb_valid_i = fld[0][0];
    wb_pc_i = fld[1];
    {wb_mpu_fault_i, wb_bus_err_i, wb_ebrk_i, wb_ecall_i, wb_sys_en_i, wb_illegal_i} = fld[2][5:0];
    {irq_ack_i, dbg_async_pend_i, dbg_async_allow_i} = fld[3][4:2];
    {dbg_sync_pend_i, dbg_sync_allow_i} = fld[3][1:0];
    pc_mux_i = pc_mux_e'(fld[4][3:0]);
    debug_mode_n_i = fld[5][0];
    priv_lvl_i = privlvl_e'(fld[6][1:0]);
    {csr_save_cause_i, cause_irq_i} = {fld[7][0], fld[8][0]};
    cause_code_i = fld[9][EXC_CODE_W-1:0];
    mepc_n_i = fld[10];
    {exp_ierr, exp_derr} = {fld[11][0], fld[12][0]};
    {exp_checked, exp_mismatch} = {fld[13][5:0], fld[14][5:0]};
  endtask

  // Drives one line 2 ns after an edge and samples 1 ns after the following edge
  task automatic run_line(input string text);
    int n;
    n = $sscanf(text, "%s %s", test_name, line_kind);
    if (n != 2) begin
      abort_run("a vector line has no name or kind");
    end
    if (line_kind == "B") begin
      n = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  test_name, line_kind, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                  fld[6], fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                  fld[14], fld[15], fld[16]);
      if (n != 19) begin
        abort_run("a bus vector line has the wrong number of fields");
      end
      apply_bus_line();
    end else if (line_kind == "T") begin
      n = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  test_name, line_kind, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                  fld[6], fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
      if (n != 17) begin
        abort_run("a trap vector line has the wrong number of fields");
      end
      apply_trap_line();
    end else begin
      abort_run("a vector line has an unknown kind");
    end
    wait_rise(40);
    check_err("instr_integrity_err_o", exp_ierr, instr_integrity_err_o);
    check_err("data_integrity_err_o", exp_derr, data_integrity_err_o);
    check_causes("mepc_checked_o", exp_checked, mepc_checked_o);
    check_causes("mepc_mismatch_o", exp_mismatch, mepc_mismatch_o);
    #1;
  endtask

  initial begin
    void'($urandom(15));
    rst_ni = 1'b0;
    set_bus_idle();
    set_trap_idle();
    vectors = 0;
    fd = $fopen("verif/monitor_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file verif/monitor_input.txt");
    end
    // Reset spans two rising edges, release lands 2 ns after the second one
    wait_rise(40);
    wait_rise(40);
    #1;
    rst_ni = 1'b1;
    test_name = "reset";
    check_err("instr_integrity_err_o", 1'b0, instr_integrity_err_o);
    check_err("data_integrity_err_o", 1'b0, data_integrity_err_o);
    check_causes("mepc_checked_o", '0, mepc_checked_o);
    check_causes("mepc_mismatch_o", '0, mepc_mismatch_o);
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // Comment and blank lines are skipped
      if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
        run_line(line);
        vectors++;
      end
    end
    $fclose(fd);
    if (vectors > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("the vector file holds no vector lines");
    end
  end

endmodule

`default_nettype wire

/* verif/monitor_input.txt */
# B: name B rnd i_req i_par i_addr i_achk i_attr d_req d_par d_addr d_achk d_attr d_wctl d_wdata
#    ierr derr checked mismatch, attr={dbg,prot,memtype} wctl={we,be}, rnd=1 recomputes achk
# T: name T wb_valid wb_pc wb_flags ctl pc_mux dmode_n priv save irq code mepc, same four expects
#    wb_flags={mpu,bus,ebrk,ecall,sys,ill} ctl={irq_ack,apend,aallow,spend,sallow}
idle_rnd_a B 1 0 1 0 0 00 0 1 0 0 00 00 0 0 0 00 00
rd_wr_a    B 0 1 0 1000 062 1c 1 0 2004 443 04 1f 12345678 0 0 00 00
rd_wr_b    B 0 1 0 1004 023 39 1 0 3000 420 22 03 000100ff 0 0 00 00
rd_wr_c    B 0 1 0 deadbeef 065 13 1 0 ff 930 29 18 80000001 0 0 00 00
idle_rnd_b B 1 0 1 0 0 13 0 1 0 0 29 1f 0 0 0 00 00
d_achk_bad B 0 1 0 1000 062 1c 1 0 2004 442 04 1f 12345678 0 1 00 00
d_after_a  B 0 1 0 1004 023 39 1 0 3000 420 22 03 000100ff 0 1 00 00
d_after_b  B 1 0 1 0 0 00 0 1 0 0 00 00 0 0 1 00 00
i_par_bad  B 0 1 1 1004 023 39 1 0 3000 420 22 03 000100ff 1 1 00 00
i_after    B 0 1 0 deadbeef 065 13 1 0 ff 930 29 18 80000001 1 1 00 00
ill_irq    T 1 300 01 10 0 0 3 0 0 0 0 1 1 00 00
ill_save   T 0 0 00 00 0 0 3 1 0 2 400 1 1 00 00
ill_wb     T 1 400 01 00 0 0 3 0 0 0 0 1 1 00 00
ill_done   T 0 0 00 00 0 0 3 0 0 0 0 1 1 01 00
ecall_dbg  T 1 404 06 03 0 0 3 0 0 0 0 1 1 01 00
ecall_wb   T 1 408 06 00 0 0 3 0 0 0 0 1 1 01 00
ecall_save T 0 0 00 00 0 0 3 1 0 b 408 1 1 01 00
ecall_done T 0 0 00 00 0 0 3 0 0 0 0 1 1 03 00
ebrk_wb    T 1 500 0a 00 0 1 3 0 0 0 0 1 1 03 00
ebrk_save  T 0 0 00 00 0 0 3 1 0 3 504 1 1 03 00
ebrk_done  T 0 0 00 00 0 0 3 0 0 0 0 1 1 0b 08
ebrk_hold  T 0 0 00 00 0 0 3 0 0 0 0 1 1 0b 08

/* all.f */
hw/integrity_pkg.sv
hw/trap_pkg.sv
hw/instr_req_checker.sv
hw/data_req_checker.sv
hw/trap_expect_tracker.sv
hw/trap_save_tracker.sv
hw/mepc_match_checker.sv
hw/core_integrity_monitor.sv
verif/tb_core_integrity_monitor.sv
